// File: files.f
+incdir+src
src/kd_node_pkg.sv
src/kd_patch_pkg.sv
src/internal_node.sv
src/kd_tree_level.sv
src/leaf_table.sv
src/kd_tree_top.sv
tb/kd_tree_assertions.sv
tb/kd_tree_tb.sv

// File: Makefile
SOURCES := files.f $(wildcard src/*.sv src/*.svh tb/*.sv)
SIM     := obj_dir/kd_tree_sim

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES)
	verilator --binary --timing --assert -j 0 --top-module kd_tree_tb \
	  -f files.f -Mdir obj_dir -o kd_tree_sim

run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// File: tb/kd_tree_tb.sv
`timescale 1ns/1ps
`include "kd_defs.svh"

module kd_tree_tb;

  import kd_node_pkg::*;
  import kd_patch_pkg::*;

  localparam int NODES  = (1 << `KD_DEPTH) - 1;
  localparam int LEAVES = 1 << `KD_DEPTH;
  localparam logic [1:0] K_CFG   = 2'd0;  // Config write to a node or a label
  localparam logic [1:0] K_PATCH = 2'd1;  // Fixed patch with a hand-worked leaf
  localparam logic [1:0] K_RAND  = 2'd2;  // Random patch, leaf from the model
  localparam logic [1:0] K_GAP   = 2'd3;  // Idle cycles that drain the pipeline

  typedef struct packed {
    logic [1:0]  kind;
    cfg_addr_t   addr;
    logic [33:0] data;
    patch_t      patch;
    leaf_id_t    exp_leaf;
    logic [7:0]  count;     // Gap length in cycles
  } entry_t;

  typedef struct packed {
    leaf_id_t leaf;
    label_t   label;
    int       due;          // Cycle in which the result must be visible
  } exp_t;

  logic       clk = 1'b0;
  logic       rst_n;
  cfg_wr_t    cfg;
  logic       patch_valid;
  patch_t     patch;
  kd_result_t result;

  entry_t      stim[$];
  exp_t        exp_q[$];          // Expected results in issue order
  dim_idx_t    m_idx [NODES];     // Model tree, breadth-first like the config map
  dim_val_t    m_median [NODES];
  label_t      m_label [LEAVES];
  logic [15:0] lfsr_state;
  int          cycle_count = 0;
  int          limit = 1000;      // Replaced once the table length is known

  kd_tree_top u_kd_tree_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg         (cfg),
    .patch_valid (patch_valid),
    .patch       (patch),
    .result      (result)
  );

  always #10 clk = ~clk;

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_leaf(input leaf_id_t exp, input leaf_id_t act);
    if (exp !== act) begin
      $display("CHECK FAILED at %0t: result.leaf expected %0d got %0d", $time, exp, act);
      abort_run();
    end
  endtask

  task automatic check_label(input label_t exp, input label_t act);
    if (exp !== act) begin
      $display("CHECK FAILED at %0t: result.label expected 0x%04h got 0x%04h", $time, exp, act);
      abort_run();
    end
  endtask

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_patch(output patch_t p);
    logic [$bits(patch_t)-1:0] bits;
    for (int i = 0; i < $bits(patch_t); i++) begin
      lfsr_state = lfsr_next(lfsr_state);  // One step per bit taken
      bits[i] = lfsr_state[0];
    end
    p = patch_t'(bits);
  endtask

  // Walk the model from the root, children of node n sit at 2n+1 and 2n+2
  function automatic leaf_id_t model_leaf(input patch_t p);
    int       node;
    dim_val_t v;
    node = 0;
    for (int lvl = 0; lvl < `KD_DEPTH; lvl++) begin
      v = (int'(m_idx[node]) < `KD_DIMS) ? p[m_idx[node]] : '0;  // Bad index reads zero
      node = 2 * node + ((v < m_median[node]) ? 1 : 2);          // Equal goes right
    end
    return leaf_id_t'(node - NODES);
  endfunction

  // Arguments run from dimension 4 down to dimension 0
  function automatic patch_t make_patch(input int d4, d3, d2, d1, d0);
    return {dim_val_t'(d4), dim_val_t'(d3), dim_val_t'(d2), dim_val_t'(d1), dim_val_t'(d0)};
  endfunction

  function automatic entry_t node_entry(input int addr, input int idx, input int median);
    entry_t    e;
    node_cfg_t nc;
    e = '0;
    nc = '0;
    nc.idx    = dim_idx_t'(idx);
    nc.median = dim_val_t'(median);
    e.kind = K_CFG;
    e.addr = cfg_addr_t'(addr);
    e.data = 34'(nc);
    return e;
  endfunction

  function automatic entry_t label_entry(input int leaf, input int label);
    entry_t e;
    e = '0;
    e.kind = K_CFG;
    e.addr = cfg_addr_t'(8 + leaf);  // Leaves live in the upper half of the map
    e.data = 34'(label_t'(label));
    return e;
  endfunction

  function automatic entry_t patch_entry(input patch_t p, input int leaf);
    entry_t e;
    e = '0;
    e.kind     = K_PATCH;
    e.patch    = p;
    e.exp_leaf = leaf_id_t'(leaf);
    return e;
  endfunction

  function automatic entry_t rand_entry();
    entry_t e;
    e = '0;
    e.kind = K_RAND;
    return e;
  endfunction

  function automatic entry_t gap_entry(input int n);
    entry_t e;
    e = '0;
    e.kind  = K_GAP;
    e.count = 8'(n);
    return e;
  endfunction

  // Drives one table row and keeps the model in step with it
  task automatic apply_entry(input entry_t e);
    patch_t    p;
    leaf_id_t  leaf;
    node_cfg_t nc;
    exp_t      x;
    int        a;
    cfg = '0;
    patch_valid = 1'b0;
    a = int'(e.addr);
    if (e.kind == K_CFG) begin
      cfg.wen   = 1'b1;
      cfg.addr  = e.addr;
      cfg.wdata = e.data;
      if (a >= 8) begin
        m_label[a - 8] = e.data[`KD_LABEL_W-1:0];
      end else if (a < NODES) begin
        nc = node_cfg_t'(e.data[$bits(node_cfg_t)-1:0]);
        m_idx[a]    = nc.idx;
        m_median[a] = nc.median;
      end
    end else if (e.kind != K_GAP) begin
      if (e.kind == K_RAND) begin
        draw_patch(p);
        leaf = model_leaf(p);
      end else begin
        p    = e.patch;
        leaf = e.exp_leaf;
      end
      x.leaf  = leaf;
      x.label = m_label[leaf];
      x.due   = cycle_count + 4;  // Sampled on the next edge, then four stages
      exp_q.push_back(x);
      patch_valid = 1'b1;
      patch       = p;
    end
    repeat ((e.kind == K_GAP) ? int'(e.count) : 1) begin
      @(posedge clk);
      #1;
    end
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= limit) begin
      $display("Timeout after %0d cycles with %0d results outstanding", cycle_count, exp_q.size());
      abort_run();
    end
  end

  // Result is stable at the falling edge
  always @(negedge clk) begin
    exp_t x;
    if (rst_n === 1'b1 && result.valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("A result came out at %0t with no patch waiting for it", $time);
        abort_run();
      end
      x = exp_q.pop_front();
      if (cycle_count != x.due) begin
        $display("Result came out in cycle %0d instead of cycle %0d", cycle_count, x.due);
        abort_run();
      end
      check_leaf(x.leaf, result.leaf);
      check_label(x.label, result.label);
    end
  end

  initial begin
    // Unwritten tree sends everything right into leaf 7
    stim.push_back(patch_entry(make_patch(0, 0, 0, 0, 0), 7));
    stim.push_back(patch_entry(make_patch(2047, 2047, 2047, 2047, 2047), 7));
    stim.push_back(patch_entry(make_patch(5, 6, 7, 8, 9), 7));
    stim.push_back(gap_entry(6));
    stim.push_back(node_entry(0, 0, 1000));  // Root splits on d0
    stim.push_back(node_entry(1, 1, 500));
    stim.push_back(node_entry(2, 2, 1500));
    stim.push_back(node_entry(3, 3, 100));
    stim.push_back(node_entry(4, 4, 700));   // Dimension 4 from bits 54:44
    stim.push_back(node_entry(5, 0, 1200));
    stim.push_back(node_entry(6, 4, 2000));
    for (int i = 0; i < LEAVES; i++) begin
      stim.push_back(label_entry(i, 'h0a10 + i));
    end
    // One patch per leaf, several sit exactly on a median
    stim.push_back(patch_entry(make_patch(0, 50, 0, 10, 10), 0));
    stim.push_back(patch_entry(make_patch(0, 100, 0, 10, 10), 1));
    stim.push_back(patch_entry(make_patch(699, 0, 0, 500, 999), 2));
    stim.push_back(patch_entry(make_patch(700, 0, 0, 2047, 0), 3));
    stim.push_back(patch_entry(make_patch(0, 0, 0, 0, 1000), 4));
    stim.push_back(patch_entry(make_patch(0, 0, 1499, 0, 1200), 5));
    stim.push_back(patch_entry(make_patch(1999, 0, 1500, 0, 2047), 6));
    stim.push_back(patch_entry(make_patch(2047, 0, 2047, 0, 1500), 7));
    stim.push_back(gap_entry(6));
    for (int i = 0; i < 6; i++) begin
      stim.push_back(rand_entry());           // Back to back burst
    end
    stim.push_back(gap_entry(6));
    // Node 4 now splits on d3 and leaf 2 gets a new label
    stim.push_back(node_entry(4, 3, 300));
    stim.push_back(label_entry(2, 'hbeef));
    stim.push_back(patch_entry(make_patch(699, 0, 0, 500, 999), 2));
    stim.push_back(patch_entry(make_patch(700, 0, 0, 2047, 0), 2));
    stim.push_back(patch_entry(make_patch(0, 300, 0, 600, 5), 3));
    for (int i = 0; i < 4; i++) begin
      stim.push_back(rand_entry());
    end
    stim.push_back(gap_entry(8));
    limit = stim.size() * 8 + 100;

    lfsr_state = 16'd58;
    for (int i = 0; i < NODES; i++) begin
      m_idx[i]    = IDX_NONE;  // Reset state of every node
      m_median[i] = '0;
    end
    for (int i = 0; i < LEAVES; i++) begin
      m_label[i] = '0;
    end

    rst_n       = 1'b0;
    cfg         = '0;
    patch_valid = 1'b0;
    patch       = '0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    foreach (stim[i]) begin
      apply_entry(stim[i]);
    end
    cfg         = '0;
    patch_valid = 1'b0;
    repeat (5) @(posedge clk);  // Pipeline depth is four

    if (exp_q.size() != 0) begin
      $display("%0d expected results never came out", exp_q.size());
      abort_run();
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

// File: tb/kd_tree_assertions.sv
`timescale 1ns/1ps

module kd_tree_assertions (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     patch_valid,
  input logic [7:0]               leaf_valid,   // Last level strobe inside the top
  input kd_patch_pkg::kd_result_t result
);

  // Result register clears on the first edge of reset
  a_reset_quiet: assert property (@(posedge clk) !rst_n |=> !result.valid)
    else $error("result.valid high during reset");

  // A patch reaches at most one leaf per cycle
  a_leaf_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(leaf_valid))
    else $error("leaf_valid has more than one bit set");

  // Three level stages plus the result register
  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
                              result.valid == $past(patch_valid, 4))
    else $error("result.valid does not follow patch_valid by four cycles");

endmodule

bind kd_tree_top kd_tree_assertions u_kd_tree_assertions (
  .clk         (clk),
  .rst_n       (rst_n),
  .patch_valid (patch_valid),
  .leaf_valid  (leaf_valid),
  .result      (result)
);

// File: src/kd_tree_top.sv
`timescale 1ns/1ps

module kd_tree_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  kd_node_pkg::cfg_wr_t      cfg,          // Shared by every node and the leaf table
  input  logic                      patch_valid,
  input  kd_patch_pkg::patch_t      patch,
  output kd_patch_pkg::kd_result_t  result
);

  import kd_patch_pkg::*;

  logic [1:0] root_valid;   // Children of the root
  logic [3:0] mid_valid;    // Children of level 1
  logic [7:0] leaf_valid;   // One-hot leaf strobe
  patch_t     patch_l0;
  patch_t     patch_l1;

  kd_tree_level #(.LEVEL(0)) u_level0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg       (cfg),
    .valid_in  (patch_valid),
    .patch_in  (patch),
    .valid_out (root_valid),
    .patch_out (patch_l0)
  );

  kd_tree_level #(.LEVEL(1)) u_level1 (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg       (cfg),
    .valid_in  (root_valid),
    .patch_in  (patch_l0),
    .valid_out (mid_valid),
    .patch_out (patch_l1)
  );

  // The leaves only need the strobe, the patch stops here
  kd_tree_level #(.LEVEL(2)) u_level2 (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg       (cfg),
    .valid_in  (mid_valid),
    .patch_in  (patch_l1),
    .valid_out (leaf_valid),
    .patch_out ()
  );

  // Fourth stage, the result register inside the leaf table
  leaf_table u_leaf_table (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg        (cfg),
    .leaf_valid (leaf_valid),
    .result     (result)
  );

endmodule

// File: src/leaf_table.sv
`timescale 1ns/1ps
`include "kd_defs.svh"

module leaf_table (
  input  logic                        clk,
  input  logic                        rst_n,
  input  kd_node_pkg::cfg_wr_t        cfg,
  input  logic [(1 << `KD_DEPTH)-1:0] leaf_valid,   // One-hot from the last level
  output kd_patch_pkg::kd_result_t    result
);

  import kd_patch_pkg::*;

  localparam int LEAVES = 1 << `KD_DEPTH;

  label_t   labels [LEAVES];
  leaf_id_t leaf_enc;     // Leaf number of the active valid
  leaf_id_t wr_leaf;
  logic     label_wen;
  logic     res_valid;
  leaf_id_t res_leaf;
  label_t   res_label;

  // Top address bit marks the leaf half of the config space
  assign label_wen = cfg.wen && cfg.addr[`KD_ADDR_W-1];
  assign wr_leaf   = leaf_id_t'(cfg.addr[`KD_DEPTH-1:0]);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < LEAVES; i++) begin
        labels[i] <= '0;
      end
    end else if (label_wen) begin
      labels[wr_leaf] <= cfg.wdata[`KD_LABEL_W-1:0];
    end
  end

  // One-hot to binary, at most one leaf is active per cycle
  always_comb begin
    leaf_enc = '0;
    for (int i = 0; i < LEAVES; i++) begin
      if (leaf_valid[i]) leaf_enc = leaf_id_t'(i);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= |leaf_valid;   // Low when nothing reached the leaves
    end
  end

  always_ff @(posedge clk) begin
    res_leaf  <= leaf_enc;
    res_label <= labels[leaf_enc];  // Label as stored before any write this cycle
  end

  assign result = '{valid: res_valid, leaf: res_leaf, label: res_label};

endmodule

// File: src/kd_tree_level.sv
`timescale 1ns/1ps

module kd_tree_level #(
  parameter int LEVEL = 0                            // 0 is the root level
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  kd_node_pkg::cfg_wr_t        cfg,
  input  logic [(1 << LEVEL)-1:0]     valid_in,      // One bit per node in this level
  input  kd_patch_pkg::patch_t        patch_in,
  output logic [(2 << LEVEL)-1:0]     valid_out,     // Bit 2n left child of node n, 2n+1 right
  output kd_patch_pkg::patch_t        patch_out
);

  import kd_node_pkg::*;

  localparam int NODES = 1 << LEVEL;
  // Breadth-first numbering puts this level's first node at NODES-1
  localparam int BASE  = NODES - 1;

  logic [2*NODES-1:0] child_valid;   // Combinational routing from the nodes
  node_cfg_t          node_wdata;

  // Node record sits in the low bits of the config data
  assign node_wdata = cfg.wdata[$bits(node_cfg_t)-1:0];

  for (genvar n = 0; n < NODES; n++) begin : g_node
    logic node_wen;

    // Only the one node whose address matches takes the write
    assign node_wen = cfg.wen && (cfg.addr == cfg_addr_t'(BASE + n));

    internal_node u_internal_node (
      .clk         (clk),
      .rst_n       (rst_n),
      .wen         (node_wen),
      .wdata       (node_wdata),
      .valid       (valid_in[n]),
      .patch_in    (patch_in),
      .valid_left  (child_valid[2*n]),
      .valid_right (child_valid[2*n+1])
    );
  end

  // Pipeline stage for the branch valids
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_out <= '0;
    end else begin
      valid_out <= child_valid;
    end
  end

  // Patch travels alongside its valids
  always_ff @(posedge clk) begin
    patch_out <= patch_in;
  end

endmodule

// File: src/internal_node.sv
`timescale 1ns/1ps
`include "kd_defs.svh"

module internal_node (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    wen,          // Decoded from the shared config port
  input  kd_node_pkg::node_cfg_t  wdata,
  input  logic                    valid,
  input  kd_patch_pkg::patch_t    patch_in,
  output logic                    valid_left,
  output logic                    valid_right
);

  import kd_node_pkg::*;

  dim_idx_t idx;      // Dimension this node splits on
  dim_val_t median;   // Split point for that dimension
  dim_val_t sel_val;  // Selected dimension of the incoming patch
  logic     go_left;

  // Node storage, an unwritten node sends everything right
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      idx    <= IDX_NONE;
      median <= '0;
    end else if (wen) begin
      idx    <= wdata.idx;
      median <= wdata.median;
    end
  end

  // Pick the stored dimension out of the patch
  // An index past the last dimension reads as zero
  always_comb begin
    sel_val = '0;
    if (idx < dim_idx_t'(`KD_DIMS)) begin
      sel_val = patch_in[idx];
    end
  end

  assign go_left = (sel_val < median); // Equal to the median goes right

  // Routing is combinational, the level registers it
  assign valid_left  = valid & go_left;
  assign valid_right = valid & ~go_left;

endmodule

// File: src/kd_patch_pkg.sv
`include "kd_defs.svh"

package kd_patch_pkg;

  // Five dimensions with dimension 0 in the low bits
  // Dimension 4 therefore occupies bits 54:44
  typedef kd_node_pkg::dim_val_t [`KD_DIMS-1:0] patch_t;

  typedef logic [`KD_DEPTH-1:0] leaf_id_t; // Leaf number, 0 is the leftmost

  typedef logic [`KD_LABEL_W-1:0] label_t;

  // Classification output, one cycle wide per patch
  typedef struct packed {
    logic      valid;
    leaf_id_t  leaf;
    label_t    label;
  } kd_result_t;

endpackage

// File: src/kd_node_pkg.sv
`include "kd_defs.svh"

package kd_node_pkg;

  // Selects one of the patch dimensions, values past KD_DIMS-1 select nothing
  typedef logic [2:0] dim_idx_t;

  // Index held by a node that was never written
  localparam dim_idx_t IDX_NONE = 3'd7;

  typedef logic [`KD_DIM_W-1:0] dim_val_t; // One dimension or a median

  typedef logic [`KD_ADDR_W-1:0] cfg_addr_t;

  // Node record as written through the config port
  // The index sits in the low bits and the median in bits 21:11
  typedef struct packed {
    dim_val_t    median;
    logic [7:0]  spare;   // Unused, keeps the median aligned at bit 11
    dim_idx_t    idx;
  } node_cfg_t;

  // One config write, nodes at 0..6 breadth first and leaf labels at 8..15
  typedef struct packed {
    logic        wen;
    cfg_addr_t   addr;
    logic [33:0] wdata;   // Node record or label, right aligned
  } cfg_wr_t;

endpackage

// File: src/kd_defs.svh
`ifndef KD_DEFS_SVH
`define KD_DEFS_SVH

// Internal levels of the tree, so 2**KD_DEPTH leaves
`define KD_DEPTH 3

// A patch is this many dimensions laid side by side
`define KD_DIMS 5

// Width of one dimension, also the width of a node median
`define KD_DIM_W 11

// Label stored per leaf
`define KD_LABEL_W 16

// Config address space covers nodes 0..6 and leaves at 8..15
`define KD_ADDR_W 4

`endif
